// ==== files.f ====
logic/vga_pkg.sv
logic/game_pkg.sv
logic/game_if.sv
logic/vga_timing.sv
logic/game_fsm.sv
logic/screen_draw.sv
logic/output_selector.sv
logic/penalty_top.sv
tb/clock_gen.sv
tb/penalty_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the penalty shootout testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module penalty_tb -f files.f -o penalty_sim \
    && ./obj_dir/penalty_sim > sim.log 2>&1
grep -q "^TESTS PASSED$" sim.log && echo "simulation ok, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/penalty_tb.sv ====
//######################################################################
// penalty_tb
// testbench of the shootout display path, checks beam timing and the
// screen colours every cycle and plays three games against a model
//######################################################################

module penalty_tb;

    localparam int FRAME_CYCLES   = int'(vga_pkg::H_TOTAL) * int'(vga_pkg::V_TOTAL);
    localparam int TIMEOUT_CYCLES = FRAME_CYCLES * 9 / 4;    // two frames and some margin
    localparam int START_BTN = 0;
    localparam int SHOOT_BTN = 1;
    localparam int DIVE_BTN  = 2;

    // screens in state order start, shooter, keeper, winner, loser
    localparam vga_pkg::rgb_t SCREEN_BG [5]  = '{12'h008, 12'h2a3, 12'h3b3, 12'hfd0, 12'h600};
    localparam vga_pkg::rgb_t SCREEN_BOX [5] = '{12'hfff, 12'hff0, 12'hf80, 12'h0c0, 12'h888};
    localparam int BOX_X0 [5] = '{300, 100, 350, 250, 250};
    localparam int BOX_X1 [5] = '{499, 299, 449, 549, 549};
    localparam int BOX_Y0 [5] = '{200, 350, 150, 250, 250};
    localparam int BOX_Y1 [5] = '{399, 549, 449, 349, 349};

    typedef struct packed {
        game_pkg::game_state_t state;
        game_pkg::score_t      goals;
        logic [2:0]            shots;
        game_pkg::dir_t        aim;
    } game_model_t;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  shoot;
    logic                  dive_go;
    game_pkg::dir_t        aim;
    game_pkg::dir_t        dive;
    vga_pkg::hcount_t      hcount;
    vga_pkg::vcount_t      vcount;
    logic                  hsync;
    logic                  vsync;
    logic                  hblnk;
    logic                  vblnk;
    vga_pkg::rgb_t         rgb;
    game_pkg::game_state_t game_state;
    game_pkg::score_t      goals;

    int                    video_errors;
    int                    game_errors;
    int                    frames_seen;
    int                    fill_cycles;
    int                    cycle_count;
    logic [31:0]           lcg_state;
    vga_pkg::hcount_t      exp_h;
    vga_pkg::vcount_t      exp_v;
    logic [3:0]            sync_exp;
    vga_pkg::rgb_t         rgb_exp;
    game_pkg::game_state_t prev_state;
    game_model_t           model;

    clock_gen #(.PERIOD(20), .RESET_CYCLES(10)) u_clock (.clk, .rst);

    penalty_top DUT (
        .clk, .rst, .start, .shoot, .aim, .dive_go, .dive,
        .hcount, .vcount, .hsync, .vsync, .hblnk, .vblnk, .rgb,
        .game_state, .goals
    );

    function automatic int unsigned next_random(input int unsigned span);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 16) % span;    // upper bits have the longer period
    endfunction

    // {hsync, vsync, hblnk, vblnk}
    function automatic logic [3:0] expected_sync(input vga_pkg::hcount_t h,
                                                 input vga_pkg::vcount_t v);
        logic hs;
        logic vs;
        hs = (h >= vga_pkg::H_ACTIVE + vga_pkg::H_FP) &&
             (h < vga_pkg::H_ACTIVE + vga_pkg::H_FP + vga_pkg::H_SYNC);
        vs = (v >= vga_pkg::V_ACTIVE + vga_pkg::V_FP) &&
             (v < vga_pkg::V_ACTIVE + vga_pkg::V_FP + vga_pkg::V_SYNC);
        return {hs, vs, h >= vga_pkg::H_ACTIVE, v >= vga_pkg::V_ACTIVE};
    endfunction

    function automatic vga_pkg::rgb_t expected_rgb(input vga_pkg::hcount_t h,
                                                   input vga_pkg::vcount_t v,
                                                   input game_pkg::game_state_t s);
        int idx;
        idx = int'(s);
        if (idx > 4) idx = 0;    // unknown state shows the start screen
        if (h >= vga_pkg::H_ACTIVE || v >= vga_pkg::V_ACTIVE) return vga_pkg::RGB_BLACK;
        if (int'(h) >= BOX_X0[idx] && int'(h) <= BOX_X1[idx] &&
            int'(v) >= BOX_Y0[idx] && int'(v) <= BOX_Y1[idx]) return SCREEN_BOX[idx];
        return SCREEN_BG[idx];
    endfunction

    function automatic game_model_t next_game(input game_model_t m, input logic st,
                                              input logic sh, input logic dg,
                                              input game_pkg::dir_t a, input game_pkg::dir_t d);
        game_model_t n;
        n = m;
        case (m.state)
            game_pkg::START: begin
                if (st) n.state = game_pkg::SHOOTER;
            end
            game_pkg::SHOOTER: begin
                if (sh) begin
                    n.state = game_pkg::KEEPER;
                    n.aim   = a;
                end
            end
            game_pkg::KEEPER: begin
                if (dg) begin
                    if (d != m.aim) n.goals = m.goals + 3'd1;    // keeper went the wrong way
                    n.shots = m.shots + 3'd1;
                    if (n.shots < game_pkg::SHOTS_PER_GAME) n.state = game_pkg::SHOOTER;
                    else if (n.goals >= game_pkg::GOALS_TO_WIN) n.state = game_pkg::WINNER;
                    else n.state = game_pkg::LOOSER;
                end
            end
            game_pkg::WINNER, game_pkg::LOOSER: begin
                if (st) begin
                    n.state = game_pkg::START;
                    n.goals = '0;
                    n.shots = '0;
                end
            end
            default: n.state = game_pkg::START;
        endcase
        return n;
    endfunction

    task automatic video_mismatch(input string name, input int expected, input int actual);
        $display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        video_errors++;
    endtask

    task automatic game_mismatch(input string name, input int expected, input int actual);
        $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        game_errors++;
    endtask

    // outputs are read at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (rst) begin
            fill_cycles = 0;
            exp_h       = '0;
            exp_v       = '0;
            prev_state  = game_pkg::START;
            model.state = game_pkg::START;
            model.goals = '0;
            model.shots = '0;
            model.aim   = '0;
        end else begin
            if (fill_cycles < 2) begin
                // the two video register stages still hold their reset values
                assert ({hcount, vcount, hsync, vsync, hblnk, vblnk, rgb} == '0) else begin
                    $display("[ERROR] t=%0t video ports expected 0x0 got 0x%0h", $time,
                             {hcount, vcount, hsync, vsync, hblnk, vblnk, rgb});
                    video_errors++;
                end
                fill_cycles++;
            end else begin
                sync_exp = expected_sync(exp_h, exp_v);
                rgb_exp  = expected_rgb(exp_h, exp_v, prev_state);
                assert (hcount == exp_h) else video_mismatch("hcount", int'(exp_h), int'(hcount));
                assert (vcount == exp_v) else video_mismatch("vcount", int'(exp_v), int'(vcount));
                assert (hsync == sync_exp[3])
                    else video_mismatch("hsync", int'(sync_exp[3]), int'(hsync));
                assert (vsync == sync_exp[2])
                    else video_mismatch("vsync", int'(sync_exp[2]), int'(vsync));
                assert (hblnk == sync_exp[1])
                    else video_mismatch("hblnk", int'(sync_exp[1]), int'(hblnk));
                assert (vblnk == sync_exp[0])
                    else video_mismatch("vblnk", int'(sync_exp[0]), int'(vblnk));
                assert (rgb == rgb_exp) else video_mismatch("rgb", int'(rgb_exp), int'(rgb));
                if (exp_h == vga_pkg::H_TOTAL - 11'd1) begin
                    exp_h = '0;
                    if (exp_v == vga_pkg::V_TOTAL - 11'd1) begin
                        exp_v = '0;
                        frames_seen++;
                    end else begin
                        exp_v = exp_v + 11'd1;
                    end
                end else begin
                    exp_h = exp_h + 11'd1;
                end
            end
            assert (game_state == model.state)
                else game_mismatch("game_state", int'(model.state), int'(game_state));
            assert (goals == model.goals)
                else game_mismatch("goals", int'(model.goals), int'(goals));
            prev_state = model.state;
            model      = next_game(model, start, shoot, dive_go, aim, dive);
        end
    end

    task automatic send_pulse(input int button);
        @(negedge clk);
        case (button)
            START_BTN: start = 1'b1;
            SHOOT_BTN: shoot = 1'b1;
            default:   dive_go = 1'b1;
        endcase
        @(negedge clk);
        start   = 1'b0;
        shoot   = 1'b0;
        dive_go = 1'b0;
        repeat (next_random(200)) @(negedge clk);
    endtask

    // waits until the displayed beam reaches a line of a given frame
    task automatic wait_for_line(input int frame, input vga_pkg::vcount_t row);
        while (!(frames_seen == frame && vcount == row)) @(negedge clk);
    endtask

    // mode 0 random, 1 every shot saved, 2 every shot scored
    task automatic play_game(input int mode);
        game_pkg::dir_t shot_aim;
        send_pulse(SHOOT_BTN);    // ignored at the start screen
        send_pulse(START_BTN);
        for (int shot = 0; shot < 5; shot++) begin
            send_pulse(DIVE_BTN);    // no keeper yet
            shot_aim = game_pkg::dir_t'(next_random(4));
            aim      = shot_aim;
            send_pulse(SHOOT_BTN);
            send_pulse(START_BTN);
            aim = game_pkg::dir_t'(next_random(4));    // must not move the latched aim
            case (mode)
                1:       dive = shot_aim;
                2:       dive = shot_aim + 2'd1;
                default: dive = game_pkg::dir_t'(next_random(4));
            endcase
            send_pulse(DIVE_BTN);
        end
        send_pulse(SHOOT_BTN);
        send_pulse(START_BTN);
    endtask

    initial begin
        start        = 1'b0;
        shoot        = 1'b0;
        dive_go      = 1'b0;
        aim          = '0;
        dive         = '0;
        lcg_state    = 32'd11615;
        video_errors = 0;
        game_errors  = 0;
        frames_seen  = 0;
        wait (rst == 1'b0);
        // games are placed where the beam crosses the screen boxes
        wait_for_line(0, 11'd355);
        play_game(0);
        wait_for_line(1, 11'd300);
        play_game(1);
        wait_for_line(1, 11'd320);
        play_game(2);
        while (frames_seen < 2) @(negedge clk);
        $display("errors: %0d video, %0d game", video_errors, game_errors);
        if (video_errors + game_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== tb/clock_gen.sv ====
//######################################################################
// clock_gen
// testbench clock and synchronous reset, reset held for a number of
// cycles and released between two rising edges
//######################################################################

module clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;    // falls mid cycle so the first free edge is clean
    end

endmodule

// ==== logic/penalty_top.sv ====
//######################################################################
// penalty_top
// penalty shootout display path: timing, round controller, five
// screens and the output stage, video lags the timing by two cycles
//######################################################################

module penalty_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  shoot,
    input  game_pkg::dir_t        aim,
    input  logic                  dive_go,
    input  game_pkg::dir_t        dive,
    output vga_pkg::hcount_t      hcount,
    output vga_pkg::vcount_t      vcount,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  hblnk,
    output logic                  vblnk,
    output vga_pkg::rgb_t         rgb,
    output game_pkg::game_state_t game_state,
    output game_pkg::score_t      goals
);

    game_if timing_if ();
    game_if start_if ();
    game_if shooter_if ();
    game_if keeper_if ();
    game_if winner_if ();
    game_if looser_if ();
    game_if out_if ();

    vga_timing u_timing (.clk, .rst, .vid(timing_if));

    game_fsm u_fsm (
        .clk, .rst, .start, .shoot, .dive_go, .aim, .dive,
        .state(game_state),
        .goals,
        .shots()
    );

    // dark blue with a centred white box
    screen_draw #(
        .bg_color(12'h008), .box_color(12'hfff),
        .box_x0(11'd300), .box_x1(11'd499), .box_y0(11'd200), .box_y1(11'd399)
    ) u_start (.clk, .rst, .timing(timing_if), .vid(start_if));

    screen_draw #(
        .bg_color(12'h2a3), .box_color(12'hff0),
        .box_x0(11'd100), .box_x1(11'd299), .box_y0(11'd350), .box_y1(11'd549)
    ) u_shooter (.clk, .rst, .timing(timing_if), .vid(shooter_if));

    screen_draw #(
        .bg_color(12'h3b3), .box_color(12'hf80),
        .box_x0(11'd350), .box_x1(11'd449), .box_y0(11'd150), .box_y1(11'd449)
    ) u_keeper (.clk, .rst, .timing(timing_if), .vid(keeper_if));

    screen_draw #(
        .bg_color(12'hfd0), .box_color(12'h0c0),
        .box_x0(11'd250), .box_x1(11'd549), .box_y0(11'd250), .box_y1(11'd349)
    ) u_winner (.clk, .rst, .timing(timing_if), .vid(winner_if));

    screen_draw #(
        .bg_color(12'h600), .box_color(12'h888),
        .box_x0(11'd250), .box_x1(11'd549), .box_y0(11'd250), .box_y1(11'd349)
    ) u_looser (.clk, .rst, .timing(timing_if), .vid(looser_if));

    output_selector u_sel (
        .clk, .rst, .game_state,
        .in_start(start_if), .in_shooter(shooter_if), .in_keeper(keeper_if),
        .in_winner(winner_if), .in_looser(looser_if),
        .out(out_if)
    );

    assign hcount = out_if.hcount;
    assign vcount = out_if.vcount;
    assign hsync  = out_if.hsync;
    assign vsync  = out_if.vsync;
    assign hblnk  = out_if.hblnk;
    assign vblnk  = out_if.vblnk;
    assign rgb    = out_if.rgb;

endmodule

// ==== logic/output_selector.sv ====
//######################################################################
// output_selector
// picks the renderer of the current game state and registers its
// video signals onto the output
//######################################################################

module output_selector (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::game_state_t game_state,
    game_if.in                    in_start,
    game_if.in                    in_shooter,
    game_if.in                    in_keeper,
    game_if.in                    in_winner,
    game_if.in                    in_looser,
    game_if.out                   out
);

    vga_pkg::vcount_t sel_vcount;
    logic             sel_vsync;
    logic             sel_vblnk;
    vga_pkg::hcount_t sel_hcount;
    logic             sel_hsync;
    logic             sel_hblnk;
    vga_pkg::rgb_t    sel_rgb;

    // start screen unless another state matches, which also covers bad encodings
    always_comb begin
        sel_vcount = in_start.vcount;
        sel_vsync  = in_start.vsync;
        sel_vblnk  = in_start.vblnk;
        sel_hcount = in_start.hcount;
        sel_hsync  = in_start.hsync;
        sel_hblnk  = in_start.hblnk;
        sel_rgb    = in_start.rgb;
        case (game_state)
            game_pkg::SHOOTER: begin
                sel_vcount = in_shooter.vcount;
                sel_vsync  = in_shooter.vsync;
                sel_vblnk  = in_shooter.vblnk;
                sel_hcount = in_shooter.hcount;
                sel_hsync  = in_shooter.hsync;
                sel_hblnk  = in_shooter.hblnk;
                sel_rgb    = in_shooter.rgb;
            end
            game_pkg::KEEPER: begin
                sel_vcount = in_keeper.vcount;
                sel_vsync  = in_keeper.vsync;
                sel_vblnk  = in_keeper.vblnk;
                sel_hcount = in_keeper.hcount;
                sel_hsync  = in_keeper.hsync;
                sel_hblnk  = in_keeper.hblnk;
                sel_rgb    = in_keeper.rgb;
            end
            game_pkg::WINNER: begin
                sel_vcount = in_winner.vcount;
                sel_vsync  = in_winner.vsync;
                sel_vblnk  = in_winner.vblnk;
                sel_hcount = in_winner.hcount;
                sel_hsync  = in_winner.hsync;
                sel_hblnk  = in_winner.hblnk;
                sel_rgb    = in_winner.rgb;
            end
            game_pkg::LOOSER: begin
                sel_vcount = in_looser.vcount;
                sel_vsync  = in_looser.vsync;
                sel_vblnk  = in_looser.vblnk;
                sel_hcount = in_looser.hcount;
                sel_hsync  = in_looser.hsync;
                sel_hblnk  = in_looser.hblnk;
                sel_rgb    = in_looser.rgb;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.vcount <= '0;
            out.vsync  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.hcount <= '0;
            out.hsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.rgb    <= '0;
        end else begin
            out.vcount <= sel_vcount;
            out.vsync  <= sel_vsync;
            out.vblnk  <= sel_vblnk;
            out.hcount <= sel_hcount;
            out.hsync  <= sel_hsync;
            out.hblnk  <= sel_hblnk;
            out.rgb    <= sel_rgb;
        end
    end

endmodule

// ==== logic/screen_draw.sv ====
//######################################################################
// screen_draw
// paints one game screen, a flat background with a single box, and
// passes the beam timing on with the same one cycle delay
//######################################################################

module screen_draw #(
    parameter vga_pkg::rgb_t    bg_color  = 12'h000,
    parameter vga_pkg::rgb_t    box_color = 12'hfff,
    parameter vga_pkg::hcount_t box_x0    = 11'd0,
    parameter vga_pkg::hcount_t box_x1    = 11'd0,
    parameter vga_pkg::vcount_t box_y0    = 11'd0,
    parameter vga_pkg::vcount_t box_y1    = 11'd0
) (
    input  logic clk,
    input  logic rst,
    game_if.in   timing,
    game_if.out  vid
);

    vga_pkg::rgb_t rgb_nxt;
    logic          in_box;

    // box edges are part of the box
    assign in_box = (timing.hcount >= box_x0) && (timing.hcount <= box_x1) &&
                    (timing.vcount >= box_y0) && (timing.vcount <= box_y1);

    always_comb begin
        if (timing.hblnk || timing.vblnk) begin
            rgb_nxt = vga_pkg::RGB_BLACK;    // nothing is drawn in blanking
        end else if (in_box) begin
            rgb_nxt = box_color;
        end else begin
            rgb_nxt = bg_color;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vid.vcount <= '0;
            vid.vsync  <= 1'b0;
            vid.vblnk  <= 1'b0;
            vid.hcount <= '0;
            vid.hsync  <= 1'b0;
            vid.hblnk  <= 1'b0;
            vid.rgb    <= '0;
        end else begin
            vid.vcount <= timing.vcount;
            vid.vsync  <= timing.vsync;
            vid.vblnk  <= timing.vblnk;
            vid.hcount <= timing.hcount;
            vid.hsync  <= timing.hsync;
            vid.hblnk  <= timing.hblnk;
            vid.rgb    <= rgb_nxt;
        end
    end

endmodule

// ==== logic/game_fsm.sv ====
//######################################################################
// game_fsm
// round controller of the shootout, five shots per game, a shot is a
// goal when the keeper dives away from the aim
//######################################################################

module game_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     shoot,
    input  logic                     dive_go,
    input  game_pkg::dir_t           aim,
    input  game_pkg::dir_t           dive,
    output game_pkg::game_state_t    state,
    output game_pkg::score_t         goals,
    output logic [2:0]               shots
);

    game_pkg::game_state_t state_nxt;
    game_pkg::dir_t        aim_q;      // aim held from the shoot pulse to the dive
    game_pkg::dir_t        aim_nxt;
    game_pkg::score_t      goals_nxt;
    game_pkg::score_t      goals_after;
    logic [2:0]            shots_nxt;
    logic [2:0]            shots_after;

    always_comb begin
        state_nxt   = state;
        aim_nxt     = aim_q;
        goals_nxt   = goals;
        shots_nxt   = shots;
        goals_after = goals + ((dive != aim_q) ? 3'd1 : 3'd0);
        shots_after = shots + 3'd1;
        case (state)
            game_pkg::START: begin
                if (start) state_nxt = game_pkg::SHOOTER;
            end
            game_pkg::SHOOTER: begin
                if (shoot) begin
                    state_nxt = game_pkg::KEEPER;
                    aim_nxt   = aim;
                end
            end
            game_pkg::KEEPER: begin
                if (dive_go) begin
                    goals_nxt = goals_after;
                    shots_nxt = shots_after;
                    if (shots_after < game_pkg::SHOTS_PER_GAME) begin
                        state_nxt = game_pkg::SHOOTER;
                    end else if (goals_after >= game_pkg::GOALS_TO_WIN) begin
                        state_nxt = game_pkg::WINNER;
                    end else begin
                        state_nxt = game_pkg::LOOSER;
                    end
                end
            end
            game_pkg::WINNER, game_pkg::LOOSER: begin
                if (start) begin
                    state_nxt = game_pkg::START;
                    goals_nxt = '0;
                    shots_nxt = '0;
                end
            end
            default: state_nxt = game_pkg::START;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= game_pkg::START;
            goals <= '0;
            shots <= '0;
        end else begin
            state <= state_nxt;
            goals <= goals_nxt;
            shots <= shots_nxt;
        end
        aim_q <= aim_nxt;
    end

endmodule

// ==== logic/vga_timing.sv ====
//######################################################################
// vga_timing
// free running pixel and line counters for 800x600, registered sync
// and blank derived from the same counter values, colour held black
//######################################################################

module vga_timing (
    input  logic clk,
    input  logic rst,
    game_if.out  vid
);

    vga_pkg::hcount_t hcount_nxt;
    vga_pkg::vcount_t vcount_nxt;

    always_comb begin
        hcount_nxt = vid.hcount + 11'd1;
        vcount_nxt = vid.vcount;
        if (vid.hcount == vga_pkg::H_TOTAL - 11'd1) begin
            hcount_nxt = '0;
            if (vid.vcount == vga_pkg::V_TOTAL - 11'd1) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vid.vcount + 11'd1;
            end
        end
    end

    // sync and blank are decoded from the next counts so they line up with them
    always_ff @(posedge clk) begin
        if (rst) begin
            vid.hcount <= '0;
            vid.vcount <= '0;
            vid.hsync  <= 1'b0;
            vid.vsync  <= 1'b0;
            vid.hblnk  <= 1'b0;
            vid.vblnk  <= 1'b0;
            vid.rgb    <= vga_pkg::RGB_BLACK;
        end else begin
            vid.hcount <= hcount_nxt;
            vid.vcount <= vcount_nxt;
            vid.hsync  <= (hcount_nxt >= vga_pkg::H_ACTIVE + vga_pkg::H_FP) &&
                          (hcount_nxt < vga_pkg::H_ACTIVE + vga_pkg::H_FP + vga_pkg::H_SYNC);
            vid.vsync  <= (vcount_nxt >= vga_pkg::V_ACTIVE + vga_pkg::V_FP) &&
                          (vcount_nxt < vga_pkg::V_ACTIVE + vga_pkg::V_FP + vga_pkg::V_SYNC);
            vid.hblnk  <= hcount_nxt >= vga_pkg::H_ACTIVE;
            vid.vblnk  <= vcount_nxt >= vga_pkg::V_ACTIVE;
            vid.rgb    <= vga_pkg::RGB_BLACK;    // renderers paint the pixels
        end
    end

endmodule

// ==== logic/game_if.sv ====
//######################################################################
// game_if
// one pixel worth of VGA beam position, sync, blank and colour
//######################################################################

interface game_if;

    vga_pkg::vcount_t vcount;
    logic             vsync;
    logic             vblnk;
    vga_pkg::hcount_t hcount;
    logic             hsync;
    logic             hblnk;
    vga_pkg::rgb_t    rgb;

    modport out (
        output vcount, vsync, vblnk, hcount, hsync, hblnk, rgb
    );

    modport in (
        input vcount, vsync, vblnk, hcount, hsync, hblnk, rgb
    );

endinterface

// ==== logic/game_pkg.sv ====
//######################################################################
// game_pkg
// round states and scoring limits of the penalty shootout game
//######################################################################

package game_pkg;

    // each state shows the screen of the same name
    typedef enum logic [2:0] {
        START,
        SHOOTER,
        KEEPER,
        WINNER,
        LOOSER
    } game_state_t;

    typedef logic [1:0] dir_t;     // aim of the shooter or dive of the keeper
    typedef logic [2:0] score_t;

    localparam logic [2:0] SHOTS_PER_GAME = 3'd5;
    localparam score_t     GOALS_TO_WIN   = 3'd3;   // at least this many goals wins

endpackage

// ==== logic/vga_pkg.sv ====
//######################################################################
// vga_pkg
// VGA 800x600 timing constants and the pixel types shared by the
// timing generator, the screen renderers and the output stage
//######################################################################

package vga_pkg;

    typedef logic [10:0] hcount_t;
    typedef logic [10:0] vcount_t;
    typedef logic [11:0] rgb_t;    // 4 bits each of red, green, blue

    // horizontal timing in pixels
    localparam hcount_t H_ACTIVE = 11'd800;
    localparam hcount_t H_FP     = 11'd40;
    localparam hcount_t H_SYNC   = 11'd128;
    localparam hcount_t H_TOTAL  = 11'd1056;

    // vertical timing in lines
    localparam vcount_t V_ACTIVE = 11'd600;
    localparam vcount_t V_FP     = 11'd1;
    localparam vcount_t V_SYNC   = 11'd4;
    localparam vcount_t V_TOTAL  = 11'd628;

    localparam rgb_t RGB_BLACK = 12'h000;

endpackage
